// ==== Makefile ====
# Verilator flow for the MIPS decode stage testbench

.PHONY: all lint clean

all: obj_dir/VdecodeTb
	./obj_dir/VdecodeTb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

obj_dir/VdecodeTb: src.f hw/mips_settings.svh $(wildcard hw/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module decodeTb -o VdecodeTb

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f src.f --top-module decodeTb

clean:
	rm -rf obj_dir sim.log

// ==== hw/branchUnit.sv ====
// ########################################
// Branch unit
// Compares the operands, picks the target
// and reports a taken redirect
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module branchUnit (
	input  mipsPkg::compareCode    compareCode,
	input  mipsPkg::branchSrc      branchSrc,
	input  logic [`DATA_W-1:0]     rsData,
	input  logic [`DATA_W-1:0]     rtData,
	input  logic [`DATA_W-1:0]     pcPlus4,
	input  mipsPkg::instrWord      instr,
	output logic                   taken,
	output logic [`DATA_W-1:0]     target
);
	import mipsPkg::*;

	logic [`DATA_W-1:0]   branchOffset;
	logic [`DATA_W-1:0]   jumpAddr;
	logic [`TARGET_W-1:0] jumpField;
	logic                 opEqual;
	logic                 opGreater;

	// Signed compare for BGT and BLE
	assign opEqual = (rsData == rtData);
	assign opGreater = ($signed(rsData) > $signed(rtData));

	always_comb begin
		case (compareCode)
			cmpEq:   taken = opEqual;
			cmpNe:   taken = !opEqual;
			cmpGt:   taken = opGreater;
			cmpLe:   taken = !opGreater;
			cmpJump: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// Word offset, sign extended and scaled by four
	assign branchOffset = {{(`DATA_W-`IMM_W-2){instr.iFields.imm16[`IMM_W-1]}},
		instr.iFields.imm16, 2'b00};

	// J-format target sits in the low bits of the I view
	assign jumpField = instr.iFields[`TARGET_W-1:0];

	// Keep the 256 MB region of the next PC
	assign jumpAddr = {pcPlus4[`DATA_W-1:`TARGET_W+2], jumpField, 2'b00};

	always_comb begin
		case (branchSrc)
			srcPcRel: target = pcPlus4 + branchOffset;
			srcAbs:   target = jumpAddr;
			srcReg:   target = rsData;
			default:  target = pcPlus4;
		endcase
	end

endmodule

// ==== hw/controlUnit.sv ====
// ########################################
// Control unit
// Decodes opcode and function into the
// control word and the branch fields
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module controlUnit (
	input  logic [`OPCODE_W-1:0]     opcode,
	input  logic [`FUNCT_W-1:0]      funct,
	output logic [`CONTROL_SIZE-1:0] controlOut,
	output logic                     isJump,
	output mipsPkg::branchSrc        branchSrc,
	output mipsPkg::compareCode      compareCode
);
	import mipsPkg::*;

	// Control word layout, high to low
	// aluSrc | regDest[1:0] | memRead | memWrite | regWrite | regSrc[1:0]
	// aluSrc set means the immediate feeds the ALU
	always_comb begin
		// Unknown opcodes fall through as a bubble
		controlOut = '0;
		isJump = 1'b0;
		branchSrc = srcPcRel;
		compareCode = cmpNone;

		case (opcode)
			`R_TYPE: begin
				if (funct == `JR) begin
					// Jump to rs, nothing written
					isJump = 1'b1;
					branchSrc = srcReg;
					compareCode = cmpJump;
				end else begin
					// ALU result into rd
					controlOut[`CTRL_REG_DEST_HI:`CTRL_REG_DEST_LO] = `REG_DEST_RD;
					controlOut[`CTRL_REG_WRITE] = 1'b1;
					controlOut[`CTRL_REG_SRC_HI:`CTRL_REG_SRC_LO] = `REG_SRC_ALU;
				end
			end

			`J: begin
				isJump = 1'b1;
				branchSrc = srcAbs;
				compareCode = cmpJump;
			end

			`JAL: begin
				isJump = 1'b1;
				branchSrc = srcAbs;
				compareCode = cmpJump;
				// Return address into the link register
				controlOut[`CTRL_REG_DEST_HI:`CTRL_REG_DEST_LO] = `REG_DEST_LINK;
				controlOut[`CTRL_REG_WRITE] = 1'b1;
				controlOut[`CTRL_REG_SRC_HI:`CTRL_REG_SRC_LO] = `REG_SRC_PC4;
			end

			`ADDI, `SLTI, `ANDI, `ORI: begin
				// Immediate ALU op into rt
				controlOut[`CTRL_ALU_SRC] = 1'b1;
				controlOut[`CTRL_REG_DEST_HI:`CTRL_REG_DEST_LO] = `REG_DEST_RT;
				controlOut[`CTRL_REG_WRITE] = 1'b1;
				controlOut[`CTRL_REG_SRC_HI:`CTRL_REG_SRC_LO] = `REG_SRC_ALU;
			end

			// Conditional branches carry no control bits
			`BEQ: compareCode = cmpEq;
			`BNE: compareCode = cmpNe;
			`BGT: compareCode = cmpGt;
			`BLE: compareCode = cmpLe;

			`LW: begin
				// Address from rs plus imm, memory data into rt
				controlOut[`CTRL_ALU_SRC] = 1'b1;
				controlOut[`CTRL_REG_DEST_HI:`CTRL_REG_DEST_LO] = `REG_DEST_RT;
				controlOut[`CTRL_MEM_READ] = 1'b1;
				controlOut[`CTRL_REG_WRITE] = 1'b1;
				controlOut[`CTRL_REG_SRC_HI:`CTRL_REG_SRC_LO] = `REG_SRC_MEM;
			end

			`SW: begin
				controlOut[`CTRL_ALU_SRC] = 1'b1;
				controlOut[`CTRL_MEM_WRITE] = 1'b1;
			end

			default: begin
				controlOut = '0;
			end
		endcase
	end

endmodule

// ==== hw/decodeStage.sv ====
// ########################################
// Decode stage
// Control, register read, branch resolve,
// hazards and the ID/EX pipeline register
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module decodeStage (
	input  logic                     clk,
	input  logic                     rstN,
	input  mipsPkg::instrWord        instr,
	input  logic [`DATA_W-1:0]       pcPlus4,
	input  logic                     wbWrite,
	input  logic [`REG_ADDR_W-1:0]   wbAddr,
	input  logic [`DATA_W-1:0]       wbData,
	output logic                     pcWrite,
	output logic                     ifFlush,
	output logic                     branchTaken,
	output logic [`DATA_W-1:0]       branchTarget,
	output logic [`CONTROL_SIZE-1:0] exControl,
	output logic [`DATA_W-1:0]       exRsData,
	output logic [`DATA_W-1:0]       exRtData,
	output logic [`DATA_W-1:0]       exImm,
	output logic [`REG_ADDR_W-1:0]   exDest,
	output logic [`DATA_W-1:0]       exPcPlus4
);
	import mipsPkg::*;

	logic [`CONTROL_SIZE-1:0] ctrl;
	logic                     isJump;
	compareCode               cmpCode;
	branchSrc                 brSrc;
	logic [`DATA_W-1:0]       rsData;
	logic [`DATA_W-1:0]       rtData;
	logic [`DATA_W-1:0]       imm;
	logic [`REG_ADDR_W-1:0]   dest;
	logic                     zeroExt;
	logic                     stall;

	controlUnit i_control (
		.opcode      (instr.rFields.opcode),
		.funct       (instr.rFields.funct),
		.controlOut  (ctrl),
		.isJump      (isJump),
		.branchSrc   (brSrc),
		.compareCode (cmpCode)
	);

	registerFile i_regFile (
		.clk    (clk),
		.rstN   (rstN),
		.rsAddr (instr.rFields.rs),
		.rtAddr (instr.rFields.rt),
		.wrEn   (wbWrite),
		.wrAddr (wbAddr),
		.wrData (wbData),
		.rsData (rsData),
		.rtData (rtData)
	);

	branchUnit i_branch (
		.compareCode (cmpCode),
		.branchSrc   (brSrc),
		.rsData      (rsData),
		.rtData      (rtData),
		.pcPlus4     (pcPlus4),
		.instr       (instr),
		.taken       (branchTaken),
		.target      (branchTarget)
	);

	// Jumps always redirect whatever the compare says
	hazardUnit i_hazard (
		.rs        (instr.rFields.rs),
		.rt        (instr.rFields.rt),
		.exMemRead (exControl[`CTRL_MEM_READ]),
		.exDest    (exDest),
		.taken     (branchTaken || isJump),
		.stall     (stall),
		.pcWrite   (pcWrite),
		.ifFlush   (ifFlush)
	);

	// Logical immediates are zero extended
	assign zeroExt = (instr.iFields.opcode == `ANDI) || (instr.iFields.opcode == `ORI);
	assign imm = zeroExt ? {{(`DATA_W-`IMM_W){1'b0}}, instr.iFields.imm16} :
		{{(`DATA_W-`IMM_W){instr.iFields.imm16[`IMM_W-1]}}, instr.iFields.imm16};

	// Destination register from regDest
	always_comb begin
		case (ctrl[`CTRL_REG_DEST_HI:`CTRL_REG_DEST_LO])
			`REG_DEST_RD:   dest = instr.rFields.rd;
			`REG_DEST_RT:   dest = instr.rFields.rt;
			`REG_DEST_LINK: dest = `LINK_REG;
			default:        dest = '0;
		endcase
	end

	// ID/EX register
	// A stall inserts a bubble while fetch holds the instruction
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exControl <= '0;
			exRsData <= '0;
			exRtData <= '0;
			exImm <= '0;
			exDest <= '0;
			exPcPlus4 <= '0;
		end else if (stall) begin
			exControl <= '0;
			exRsData <= '0;
			exRtData <= '0;
			exImm <= '0;
			exDest <= '0;
			exPcPlus4 <= '0;
		end else begin
			exControl <= ctrl;
			exRsData <= rsData;
			exRtData <= rtData;
			exImm <= imm;
			exDest <= dest;
			exPcPlus4 <= pcPlus4;
		end
	end

endmodule

// ==== hw/hazardUnit.sv ====
// ########################################
// Hazard unit
// Load-use stall and IF/ID flush on a
// taken branch or jump
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module hazardUnit (
	input  logic [`REG_ADDR_W-1:0] rs,
	input  logic [`REG_ADDR_W-1:0] rt,
	input  logic                   exMemRead,
	input  logic [`REG_ADDR_W-1:0] exDest,
	input  logic                   taken,
	output logic                   stall,
	output logic                   pcWrite,
	output logic                   ifFlush
);

	logic loadPending;
	logic rsMatch;
	logic rtMatch;

	// Load in EX whose result is not yet available
	// Register zero never creates a dependency
	assign loadPending = exMemRead && (exDest != '0);

	// Field compare only, no check whether the operand is really used
	assign rsMatch = (exDest == rs);
	assign rtMatch = (exDest == rt);

	assign stall = loadPending && (rsMatch || rtMatch);

	// Fetch holds PC and IF/ID while stalled
	assign pcWrite = !stall;

	// A stalled branch may see stale operands
	// It resolves again next cycle so no flush yet
	assign ifFlush = taken && !stall;

endmodule

// ==== hw/mipsPkg.sv ====
// ########################################
// MIPS decode package
// Instruction word views and the enums
// for branch compare and target source
// ########################################
`include "mips_settings.svh"

package mipsPkg;

	// R-format view
	typedef struct packed {
		logic [`OPCODE_W-1:0]   opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`SHAMT_W-1:0]    shamt;
		logic [`FUNCT_W-1:0]    funct;
	} rFormat;

	// I-format view
	// Low 26 bits double as the J-format target
	typedef struct packed {
		logic [`OPCODE_W-1:0]   opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`IMM_W-1:0]      imm16;
	} iFormat;

	// One 32-bit word, two decodings
	typedef union packed {
		rFormat rFields;
		iFormat iFields;
	} instrWord;

	// Branch compare code, same numbering as the control table
	typedef enum logic [2:0] {
		cmpNone = 3'd0,
		cmpEq   = 3'd1,
		cmpNe   = 3'd2,
		cmpGt   = 3'd3,
		cmpLe   = 3'd4,
		cmpJump = 3'd5
	} compareCode;

	// Where the redirect target comes from
	typedef enum logic [1:0] {
		srcPcRel = 2'd0,
		srcAbs   = 2'd1,
		srcReg   = 2'd2
	} branchSrc;

endpackage

// ==== hw/mips_settings.svh ====
// ########################################
// MIPS decode settings
// Field widths, opcode and function codes,
// control word layout and link register
// ########################################
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath and instruction field widths
`define DATA_W       32
`define REG_ADDR_W   5
`define REG_COUNT    32
`define OPCODE_W     6
`define FUNCT_W      6
`define SHAMT_W      5
`define IMM_W        16
`define TARGET_W     26
`define CONTROL_SIZE 8

// Register written by JAL
`define LINK_REG 5'd31

// Opcodes
`define R_TYPE 6'h00
`define J      6'h02
`define JAL    6'h03
`define BEQ    6'h04
`define BNE    6'h05
`define BLE    6'h06
`define BGT    6'h07
`define ADDI   6'h08
`define SLTI   6'h0A
`define ANDI   6'h0C
`define ORI    6'h0D
`define LW     6'h23
`define SW     6'h2B

// Function code of JR under R_TYPE
`define JR 6'h08

// Control word bit positions
`define CTRL_ALU_SRC     7
`define CTRL_REG_DEST_HI 6
`define CTRL_REG_DEST_LO 5
`define CTRL_MEM_READ    4
`define CTRL_MEM_WRITE   3
`define CTRL_REG_WRITE   2
`define CTRL_REG_SRC_HI  1
`define CTRL_REG_SRC_LO  0

// regDest field values
`define REG_DEST_RD   2'd0
`define REG_DEST_RT   2'd1
`define REG_DEST_LINK 2'd2

// regSrc field values
`define REG_SRC_ALU 2'd0
`define REG_SRC_MEM 2'd1
`define REG_SRC_PC4 2'd2

`endif

// ==== hw/registerFile.sv ====
// ########################################
// Register file
// 32 x 32 bits, two reads and one write
// Register zero always reads zero
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module registerFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [`REG_ADDR_W-1:0] rsAddr,
	input  logic [`REG_ADDR_W-1:0] rtAddr,
	input  logic                   wrEn,
	input  logic [`REG_ADDR_W-1:0] wrAddr,
	input  logic [`DATA_W-1:0]     wrData,
	output logic [`DATA_W-1:0]     rsData,
	output logic [`DATA_W-1:0]     rtData
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	// Shared read path for both ports
	// A write to the same register this cycle is passed straight through
	function automatic logic [`DATA_W-1:0] readPort(
		input logic [`REG_ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0]     stored
	);
		logic bypass;
		bypass = wrEn && (wrAddr == addr) && (addr != '0);
		return bypass ? wrData : stored;
	endfunction

	always_comb begin
		rsData = readPort(rsAddr, regs[rsAddr]);
		rtData = readPort(rtAddr, regs[rtAddr]);
	end

	// Write port
	// Register zero is never written so it keeps its reset value
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// ==== src.f ====
+incdir+hw
hw/mipsPkg.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/branchUnit.sv
hw/hazardUnit.sv
hw/decodeStage.sv
verif/decodeChecker.sv
verif/decodeTb.sv

// ==== verif/decodeChecker.sv ====
// ########################################
// Decode stage checker
// Shadow register file and rule model,
// compares DUT outputs and counts errors
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module decodeChecker (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] instr,
	input  logic [31:0] pcPlus4,
	input  logic        wbWrite,
	input  logic [4:0]  wbAddr,
	input  logic [31:0] wbData,
	input  logic        pcWrite,
	input  logic        ifFlush,
	input  logic        branchTaken,
	input  logic [31:0] branchTarget,
	input  logic [7:0]  exControl,
	input  logic [31:0] exRsData,
	input  logic [31:0] exRtData,
	input  logic [31:0] exImm,
	input  logic [4:0]  exDest,
	input  logic [31:0] exPcPlus4,
	input  logic        rowValid,
	input  int          rowIdx,
	input  int          rowGroup,
	input  int          rowTotal,
	input  logic        done,
	output int          errorCount
);

	logic [31:0] shadow [32];
	int          rowErr [64];
	int          resetErr;
	int          rowsDone;
	int          stallsSeen;
	logic        summaryDone;
	// Expected ID/EX contents after the last rising edge
	logic [7:0]  expCtrl;
	logic [31:0] expRs;
	logic [31:0] expRt;
	logic [31:0] expImm;
	logic [31:0] expPc;
	logic [4:0]  expDest;
	int          pendRow;
	int          pendGroup;
	logic        pendPrint;

	// Committed value or the write landing at the next edge
	function automatic logic [31:0] readReg(input logic [4:0] addr);
		if (addr == 5'd0) return '0;
		if (wbWrite && (wbAddr == addr)) return wbData;
		return shadow[addr];
	endfunction

	// aluSrc | regDest | memRead | memWrite | regWrite | regSrc
	function automatic logic [7:0] ctrlFor(input logic [5:0] op, input logic [5:0] fn);
		case (op)
			`R_TYPE: return (fn == `JR) ? 8'h00 : 8'h04;
			`JAL: return 8'h46;
			`ADDI, `SLTI, `ANDI, `ORI: return 8'hA4;
			`LW: return 8'hB5;
			`SW: return 8'h88;
			default: return 8'h00;
		endcase
	endfunction

	function automatic string groupName(input int grp);
		case (grp)
			1: return "register file";
			2: return "control word";
			3: return "branch";
			4: return "jump";
			default: return "load-use";
		endcase
	endfunction

	task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act,
		input int row);
		if (exp !== act) begin
			$display("[ERROR] %0t ns %s expected %08h actual %08h", $time, sig, exp, act);
			errorCount++;
			if (row >= 0) rowErr[row]++;
			else if (row == -1) resetErr++;
		end
	endtask

	always @(negedge clk) begin
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] target;
		logic [7:0]  ctrl;
		logic        stall;
		logic        taken;
		logic        hasTarget;
		int          row;
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] = '0;
			end
			{expCtrl, expRs, expRt, expImm, expPc, expDest} = '0;
			pendRow = -1;
			pendPrint = 1'b1;
			summaryDone = 1'b0;
		end else begin
			compare("exControl", 32'(expCtrl), 32'(exControl), pendRow);
			compare("exRsData", expRs, exRsData, pendRow);
			compare("exRtData", expRt, exRtData, pendRow);
			compare("exImm", expImm, exImm, pendRow);
			compare("exDest", 32'(expDest), 32'(exDest), pendRow);
			compare("exPcPlus4", expPc, exPcPlus4, pendRow);
			if (pendPrint && (pendRow == -1)) begin
				$display("reset: %s", (resetErr == 0) ? "pass" : "fail");
			end else if (pendPrint) begin
				$display("test %0d %s: %s", pendRow, groupName(pendGroup),
					(rowErr[pendRow] == 0) ? "pass" : "fail");
				rowsDone++;
			end

			// Instruction presented in this cycle
			op = instr[31:26];
			rs = instr[25:21];
			rt = instr[20:16];
			imm16 = instr[15:0];
			row = rowValid ? rowIdx : -2;
			rsVal = readReg(rs);
			rtVal = readReg(rt);
			ctrl = ctrlFor(op, instr[5:0]);
			stall = expCtrl[`CTRL_MEM_READ] && (expDest != 5'd0) &&
				((expDest == rs) || (expDest == rt));
			if (!pcWrite) stallsSeen++;

			taken = 1'b0;
			hasTarget = 1'b1;
			target = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
			case (op)
				`BEQ: taken = (rsVal == rtVal);
				`BNE: taken = (rsVal != rtVal);
				`BGT: taken = ($signed(rsVal) > $signed(rtVal));
				`BLE: taken = ($signed(rsVal) <= $signed(rtVal));
				`J, `JAL: begin
					taken = 1'b1;
					target = {pcPlus4[31:28], instr[25:0], 2'b00};
				end
				default: begin
					// Only JR redirects among the rest
					hasTarget = (op == `R_TYPE) && (instr[5:0] == `JR);
					taken = hasTarget;
					target = rsVal;
				end
			endcase
			compare("pcWrite", 32'(!stall), 32'(pcWrite), row);
			compare("branchTaken", 32'(taken), 32'(branchTaken), row);
			compare("ifFlush", 32'(taken && !stall), 32'(ifFlush), row);
			if (hasTarget) compare("branchTarget", target, branchTarget, row);

			// What the ID/EX register should hold after the next edge
			if (stall) begin
				{expCtrl, expRs, expRt, expImm, expPc, expDest} = '0;
				pendPrint = 1'b0;
			end else begin
				expCtrl = ctrl;
				expRs = rsVal;
				expRt = rtVal;
				expPc = pcPlus4;
				if ((op == `ANDI) || (op == `ORI)) expImm = {16'h0000, imm16};
				else expImm = {{16{imm16[15]}}, imm16};
				case (ctrl[`CTRL_REG_DEST_HI:`CTRL_REG_DEST_LO])
					2'd0: expDest = instr[15:11];
					2'd1: expDest = rt;
					2'd2: expDest = `LINK_REG;
					default: expDest = 5'd0;
				endcase
				pendPrint = rowValid;
			end
			pendRow = row;
			pendGroup = rowGroup;
			if (wbWrite && (wbAddr != 5'd0)) shadow[wbAddr] = wbData;

			if (done && !summaryDone) begin
				if (stallsSeen == 0) begin
					$display("No load-use stall was seen during the run");
					errorCount++;
				end
				if (rowsDone != rowTotal) begin
					$display("Only %0d of %0d table rows reached the ID/EX register",
						rowsDone, rowTotal);
					errorCount++;
				end
				$display("summary: %0d tests, %0d stalls, %0d errors", rowsDone, stallsSeen,
					errorCount);
				summaryDone = 1'b1;
			end
		end
	end

endmodule

// ==== verif/decodeTb.sv ====
// ########################################
// Decode stage testbench
// Clock, reset, watchdog and a stimulus
// table run through the DUT in order
// ########################################
`timescale 1ns/1ps
`include "mips_settings.svh"

module decodeTb;

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_ROWS = 64;

	logic        clk;
	logic        rstN;
	logic [31:0] instr;
	logic [31:0] pcPlus4;
	logic        wbWrite;
	logic [4:0]  wbAddr;
	logic [31:0] wbData;
	logic        pcWrite;
	logic        ifFlush;
	logic        branchTaken;
	logic [31:0] branchTarget;
	logic [7:0]  exControl;
	logic [31:0] exRsData;
	logic [31:0] exRtData;
	logic [31:0] exImm;
	logic [4:0]  exDest;
	logic [31:0] exPcPlus4;
	logic        rowValid;
	int          rowIdx;
	int          rowGroup;
	logic        done;
	int          checkErrors;
	int          seed;
	int          idx;

	// Stimulus table, one row per instruction
	int          rowCount;
	int          tGroup [MAX_ROWS];
	logic        tWrite [MAX_ROWS];
	logic [4:0]  tAddr [MAX_ROWS];
	logic [31:0] tData [MAX_ROWS];
	logic [31:0] tInstr [MAX_ROWS];
	logic [31:0] tPc [MAX_ROWS];

	decodeStage i_dut (
		.clk(clk), .rstN(rstN), .instr(instr), .pcPlus4(pcPlus4),
		.wbWrite(wbWrite), .wbAddr(wbAddr), .wbData(wbData),
		.pcWrite(pcWrite), .ifFlush(ifFlush), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .exControl(exControl), .exRsData(exRsData),
		.exRtData(exRtData), .exImm(exImm), .exDest(exDest), .exPcPlus4(exPcPlus4)
	);

	decodeChecker i_check (
		.clk(clk), .rstN(rstN), .instr(instr), .pcPlus4(pcPlus4),
		.wbWrite(wbWrite), .wbAddr(wbAddr), .wbData(wbData),
		.pcWrite(pcWrite), .ifFlush(ifFlush), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .exControl(exControl), .exRsData(exRsData),
		.exRtData(exRtData), .exImm(exImm), .exDest(exDest), .exPcPlus4(exPcPlus4),
		.rowValid(rowValid), .rowIdx(rowIdx), .rowGroup(rowGroup), .rowTotal(rowCount),
		.done(done), .errorCount(checkErrors)
	);

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {`R_TYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Random write-back data, PC+4 in a nonzero 256 MB region
	task automatic addRow(input int grp, input logic wr, input logic [4:0] addr,
		input logic [31:0] word);
		tGroup[rowCount] = grp;
		tWrite[rowCount] = wr;
		tAddr[rowCount] = addr;
		tData[rowCount] = $random(seed);
		tInstr[rowCount] = word;
		tPc[rowCount] = 32'hA040_0004 + 32'(4 * rowCount);
		rowCount++;
	endtask

	task automatic buildTable();
		// Preloads with same-cycle reads, then a write to r0
		addRow(1, 1'b1, 5'd1, encodeR(5'd1, 5'd0, 5'd9, 6'h20));
		addRow(1, 1'b1, 5'd2, encodeR(5'd2, 5'd1, 5'd9, 6'h20));
		addRow(1, 1'b1, 5'd3, encodeR(5'd3, 5'd2, 5'd9, 6'h22));
		addRow(1, 1'b1, 5'd4, encodeR(5'd4, 5'd3, 5'd9, 6'h25));
		addRow(1, 1'b1, 5'd5, encodeR(5'd5, 5'd4, 5'd9, 6'h2A));
		addRow(1, 1'b1, 5'd0, encodeR(5'd0, 5'd5, 5'd9, 6'h20));
		addRow(1, 1'b0, 5'd0, encodeR(5'd0, 5'd1, 5'd9, 6'h20));
		addRow(2, 1'b0, 5'd0, encodeI(`ADDI, 5'd1, 5'd6, 16'hFFFC));
		addRow(2, 1'b0, 5'd0, encodeI(`SLTI, 5'd2, 5'd6, 16'h8000));
		addRow(2, 1'b0, 5'd0, encodeI(`ANDI, 5'd3, 5'd6, 16'h8001));
		addRow(2, 1'b0, 5'd0, encodeI(`ORI, 5'd4, 5'd6, 16'hF0F0));
		addRow(2, 1'b0, 5'd0, encodeI(`SW, 5'd1, 5'd5, 16'h0008));
		addRow(2, 1'b0, 5'd0, encodeR(5'd3, 5'd4, 5'd10, 6'h24));
		// Two unused opcodes
		addRow(2, 1'b0, 5'd0, encodeI(6'h3F, 5'd1, 5'd2, 16'h1234));
		addRow(2, 1'b0, 5'd0, encodeI(6'h10, 5'd3, 5'd4, 16'h8765));
		addRow(3, 1'b0, 5'd0, encodeI(`BEQ, 5'd1, 5'd1, 16'h0003));
		addRow(3, 1'b0, 5'd0, encodeI(`BEQ, 5'd1, 5'd2, 16'hFFFE));
		addRow(3, 1'b0, 5'd0, encodeI(`BNE, 5'd1, 5'd1, 16'h0010));
		addRow(3, 1'b0, 5'd0, encodeI(`BNE, 5'd1, 5'd2, 16'hFF00));
		addRow(3, 1'b0, 5'd0, encodeI(`BGT, 5'd1, 5'd2, 16'h0004));
		addRow(3, 1'b0, 5'd0, encodeI(`BGT, 5'd2, 5'd1, 16'h0004));
		addRow(3, 1'b0, 5'd0, encodeI(`BGT, 5'd3, 5'd3, 16'h0004));
		addRow(3, 1'b0, 5'd0, encodeI(`BLE, 5'd1, 5'd2, 16'h8000));
		addRow(3, 1'b0, 5'd0, encodeI(`BLE, 5'd2, 5'd1, 16'h7FFF));
		addRow(3, 1'b0, 5'd0, encodeI(`BLE, 5'd3, 5'd3, 16'h0001));
		addRow(4, 1'b0, 5'd0, {`J, 26'h0123456});
		addRow(4, 1'b0, 5'd0, {`JAL, 26'h3FF_FFFF});
		addRow(4, 1'b0, 5'd0, encodeR(5'd3, 5'd0, 5'd0, `JR));
		// Dependent reader right after each load
		addRow(5, 1'b0, 5'd0, encodeI(`LW, 5'd1, 5'd7, 16'h0000));
		addRow(5, 1'b0, 5'd0, encodeR(5'd7, 5'd2, 5'd9, 6'h20));
		addRow(5, 1'b0, 5'd0, encodeR(5'd3, 5'd4, 5'd9, 6'h20));
		addRow(5, 1'b0, 5'd0, encodeI(`LW, 5'd2, 5'd8, 16'h0004));
		addRow(5, 1'b0, 5'd0, encodeI(`BEQ, 5'd8, 5'd1, 16'h0002));
		addRow(5, 1'b0, 5'd0, encodeR(5'd8, 5'd8, 5'd9, 6'h20));
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Each row takes at most two cycles when it stalls
	initial begin
		wait (rowCount > 0);
		#((2 * rowCount + RESET_CYCLES + 20) * PERIOD);
		$display("Watchdog expired before the stimulus table finished");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed = 32'ha941_1929;
		rstN = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		wbWrite = 1'b0;
		wbAddr = '0;
		wbData = '0;
		rowValid = 1'b0;
		rowIdx = 0;
		rowGroup = 0;
		done = 1'b0;
		buildTable();
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		idx = 0;
		while (idx < rowCount) begin
			@(posedge clk);
			instr <= tInstr[idx];
			pcPlus4 <= tPc[idx];
			wbWrite <= tWrite[idx];
			wbAddr <= tAddr[idx];
			wbData <= tData[idx];
			rowValid <= 1'b1;
			rowIdx <= idx;
			rowGroup <= tGroup[idx];
			@(negedge clk);
			// Fetch holds the instruction while pcWrite is low
			if (pcWrite) idx++;
		end
		@(posedge clk);
		instr <= '0;
		pcPlus4 <= '0;
		wbWrite <= 1'b0;
		rowValid <= 1'b0;
		@(negedge clk);
		@(posedge clk);
		done <= 1'b1;
		@(negedge clk);
		@(posedge clk);
		if (checkErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
